//--- include/inst_defs.svh
`ifndef INST_DEFS_SVH
`define INST_DEFS_SVH

// register and instruction field ranges
`define REG_RANGE       31:0
`define REG_FIELD_RANGE 4:0
`define FUNCT_3_RANGE   2:0

// load funct3 codes
`define LB  3'b000
`define LH  3'b001
`define LW  3'b010
`define LBU 3'b100
`define LHU 3'b101

// store funct3 codes
`define SB  3'b000
`define SH  3'b001
`define SW  3'b010

`endif

//--- verilog/rv_mem_pkg.sv
`include "inst_defs.svh"

package rv_mem_pkg;

    // write-back source select, code 3 unused
    typedef enum logic [1:0] {
        ALU = 2'd0,
        PC4 = 2'd1,
        MEM = 2'd2
    } wb_src_t;

    // bundle from execute into the memory stage
    typedef struct packed {
        logic [`REG_RANGE]       alu_out;
        logic [`REG_RANGE]       pc_4;
        logic [`REG_RANGE]       store_data;
        logic [`FUNCT_3_RANGE]   funct3;
        logic [`REG_FIELD_RANGE] rd;
        logic                    reg_wr_en;
        wb_src_t                 wb_src;
        logic                    mem_rd;
        logic                    mem_wr;
        logic                    halt;
    } ex_mem_t;

    // MEM/WB pipeline register contents
    typedef struct packed {
        logic [`REG_RANGE]       alu_out;
        logic [`REG_RANGE]       pc_4;
        logic [`FUNCT_3_RANGE]   funct3;
        logic [`REG_FIELD_RANGE] rd;
        logic                    reg_wr_en;
        wb_src_t                 wb_src;
        logic                    halt;
        logic [1:0]              byte_offset;
        logic [1:0]              mem_sel;
    } mem_wb_t;

    // register write port back toward decode
    typedef struct packed {
        logic                    wr_en;
        logic [`REG_FIELD_RANGE] rd;
        logic [`REG_RANGE]       wr_data;
    } wb_id_t;

endpackage

//--- verilog/data_bank.sv
module data_bank #(
    parameter WIDTH      = 32,
    parameter BANK_DEPTH = 1024
) (
    input  logic                          clk,
    input  logic [$clog2(BANK_DEPTH)-1:0] addr,
    input  logic                          wr_en,
    input  logic [3:0]                    byte_en,
    input  logic [WIDTH-1:0]              wr_data,
    output logic [WIDTH-1:0]              rd_data
);

    localparam NUM_LANES = 4;
    localparam LANE_W    = WIDTH / NUM_LANES;

    logic [WIDTH-1:0] mem [BANK_DEPTH];

    // per-lane writes, old word comes out on a same-address write
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (wr_en && byte_en[i]) begin
                mem[addr][i*LANE_W +: LANE_W] <= wr_data[i*LANE_W +: LANE_W];
            end
        end
        rd_data <= mem[addr];
    end

endmodule

//--- verilog/mem_access.sv
`include "inst_defs.svh"

module mem_access
    import rv_mem_pkg::*;
#(
    parameter WIDTH      = 32,
    parameter BANK_DEPTH = 1024
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_valid,
    input  ex_mem_t                       ex_bundle,

    output logic [$clog2(BANK_DEPTH)-1:0] bank0_addr,
    output logic                          bank0_wr_en,
    output logic [3:0]                    bank0_byte_en,
    output logic [WIDTH-1:0]              bank0_wr_data,

    output logic [$clog2(BANK_DEPTH)-1:0] bank3_addr,
    output logic                          bank3_wr_en,
    output logic [3:0]                    bank3_byte_en,
    output logic [WIDTH-1:0]              bank3_wr_data,

    output mem_wb_t                       mem_wb
);

    localparam IDX_W = $clog2(BANK_DEPTH);

    logic [1:0]       bank_sel;
    logic [1:0]       byte_offset;
    logic [IDX_W-1:0] word_idx;
    logic [WIDTH-1:0] lane_data;
    logic [3:0]       lane_en;
    logic             store;

    // bank from bits 13:12, word index sits above the byte offset
    assign bank_sel    = ex_bundle.alu_out[13:12];
    assign byte_offset = ex_bundle.alu_out[1:0];
    assign word_idx    = ex_bundle.alu_out[IDX_W+1:2];
    assign store       = ex_valid && ex_bundle.mem_wr;

    // move store data into its byte lanes
    always_comb begin
        lane_data = WIDTH'(ex_bundle.store_data) << {byte_offset, 3'b000};
        case (ex_bundle.funct3)
            `SB:     lane_en = 4'b0001 << byte_offset;
            `SH:     lane_en = 4'b0011 << byte_offset;
            `SW:     lane_en = 4'b1111;
            default: lane_en = 4'b0000;
        endcase
    end

    // both banks see the same address and data, only the strobe differs
    assign bank0_addr    = word_idx;
    assign bank0_byte_en = lane_en;
    assign bank0_wr_data = lane_data;
    assign bank0_wr_en   = store && (bank_sel == 2'b00);

    assign bank3_addr    = word_idx;
    assign bank3_byte_en = lane_en;
    assign bank3_wr_data = lane_data;
    assign bank3_wr_en   = store && (bank_sel == 2'b11);

    // MEM/WB register, valid folded into the control bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb.reg_wr_en <= 1'b0;
            mem_wb.halt      <= 1'b0;
        end else begin
            mem_wb.reg_wr_en <= ex_valid && ex_bundle.reg_wr_en && !ex_bundle.mem_wr;
            mem_wb.halt      <= ex_valid && ex_bundle.halt;
        end
        mem_wb.alu_out     <= ex_bundle.alu_out;
        mem_wb.pc_4        <= ex_bundle.pc_4;
        mem_wb.funct3      <= ex_bundle.funct3;
        mem_wb.rd          <= ex_bundle.rd;
        mem_wb.wb_src      <= ex_bundle.wb_src;
        mem_wb.byte_offset <= byte_offset;
        mem_wb.mem_sel     <= bank_sel;
    end

    // halfword accesses on even bytes, SH and LH share the code
    a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && (ex_bundle.mem_rd || ex_bundle.mem_wr) && ex_bundle.funct3 == `SH
        |-> !byte_offset[0]);

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && (ex_bundle.mem_rd || ex_bundle.mem_wr) && ex_bundle.funct3 == `SW
        |-> byte_offset == 2'b00);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid |-> !(ex_bundle.mem_rd && ex_bundle.mem_wr));

endmodule

//--- verilog/write_back.sv
`include "inst_defs.svh"

module write_back
    import rv_mem_pkg::*;
#(
    parameter WIDTH = 32
) (
    input  mem_wb_t          mem_wb,
    input  logic [WIDTH-1:0] mem0_rd_data,
    input  logic [WIDTH-1:0] mem3_rd_data,
    output wb_id_t           wb_port,
    output logic             halt_wb
);

    logic [WIDTH-1:0] mem_word;
    logic [WIDTH-1:0] load_val;
    logic [4:0]       shamt;

    assign shamt = {mem_wb.byte_offset, 3'b000};

    // banks 1 and 2 are not fitted and read back as zero
    always_comb begin
        case (mem_wb.mem_sel)
            2'b00:   mem_word = mem0_rd_data;
            2'b11:   mem_word = mem3_rd_data;
            default: mem_word = '0;
        endcase
    end

    // pick the byte or halfword and extend by funct3
    always_comb begin
        case (mem_wb.funct3)
            `LW:     load_val = mem_word;
            `LH:     load_val = WIDTH'(signed'(mem_word[shamt +: 16]));
            `LB:     load_val = WIDTH'(signed'(mem_word[shamt +: 8]));
            `LHU:    load_val = WIDTH'(mem_word[shamt +: 16]);
            `LBU:    load_val = WIDTH'(mem_word[shamt +: 8]);
            default: load_val = '0;
        endcase
    end

    // result mux, unused source code gives zero
    always_comb begin
        wb_port.wr_en = mem_wb.reg_wr_en;
        wb_port.rd    = mem_wb.rd;
        case (mem_wb.wb_src)
            ALU:     wb_port.wr_data = mem_wb.alu_out;
            PC4:     wb_port.wr_data = mem_wb.pc_4;
            MEM:     wb_port.wr_data = load_val;
            default: wb_port.wr_data = '0;
        endcase
    end

    assign halt_wb = mem_wb.halt;

endmodule

//--- verilog/reg_file.sv
module reg_file
    import rv_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  wb_id_t      wb_port,
    input  logic [4:0]  rs_addr,
    output logic [31:0] rs_data
);

    // x1 to x31, x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wb_port.wr_en && wb_port.rd != 5'd0) begin
            regs[wb_port.rd] <= wb_port.wr_data;
        end
    end

    // no bypass, a write shows up the cycle after
    assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];

    // load data from the banks must be known by the time it is written
    a_wr_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb_port.wr_en |-> !$isunknown(wb_port.wr_data));

endmodule

//--- verilog/mem_wb_top.sv
module mem_wb_top
    import rv_mem_pkg::*;
#(
    parameter WIDTH      = 32,
    parameter BANK_DEPTH = 1024
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ex_valid,
    input  ex_mem_t     ex_bundle,
    input  logic [4:0]  rs_addr,
    output wb_id_t      wb_port,
    output logic        halt_wb,
    output logic [31:0] rs_data
);

    localparam IDX_W = $clog2(BANK_DEPTH);

    logic [IDX_W-1:0] bank0_addr;
    logic             bank0_wr_en;
    logic [3:0]       bank0_byte_en;
    logic [WIDTH-1:0] bank0_wr_data;
    logic [WIDTH-1:0] bank0_rd_data;

    logic [IDX_W-1:0] bank3_addr;
    logic             bank3_wr_en;
    logic [3:0]       bank3_byte_en;
    logic [WIDTH-1:0] bank3_wr_data;
    logic [WIDTH-1:0] bank3_rd_data;

    mem_wb_t          mem_wb;

    data_bank #(.WIDTH(WIDTH), .BANK_DEPTH(BANK_DEPTH)) bank0_i (
        .clk     (clk),
        .addr    (bank0_addr),
        .wr_en   (bank0_wr_en),
        .byte_en (bank0_byte_en),
        .wr_data (bank0_wr_data),
        .rd_data (bank0_rd_data)
    );

    data_bank #(.WIDTH(WIDTH), .BANK_DEPTH(BANK_DEPTH)) bank3_i (
        .clk     (clk),
        .addr    (bank3_addr),
        .wr_en   (bank3_wr_en),
        .byte_en (bank3_byte_en),
        .wr_data (bank3_wr_data),
        .rd_data (bank3_rd_data)
    );

    mem_access #(.WIDTH(WIDTH), .BANK_DEPTH(BANK_DEPTH)) mem_access_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_bundle     (ex_bundle),
        .bank0_addr    (bank0_addr),
        .bank0_wr_en   (bank0_wr_en),
        .bank0_byte_en (bank0_byte_en),
        .bank0_wr_data (bank0_wr_data),
        .bank3_addr    (bank3_addr),
        .bank3_wr_en   (bank3_wr_en),
        .bank3_byte_en (bank3_byte_en),
        .bank3_wr_data (bank3_wr_data),
        .mem_wb        (mem_wb)
    );

    write_back #(.WIDTH(WIDTH)) write_back_i (
        .mem_wb       (mem_wb),
        .mem0_rd_data (bank0_rd_data),
        .mem3_rd_data (bank3_rd_data),
        .wb_port      (wb_port),
        .halt_wb      (halt_wb)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_port (wb_port),
        .rs_addr (rs_addr),
        .rs_data (rs_data)
    );

endmodule

//--- dv/mem_wb_tb.sv
module mem_wb_tb
    import rv_mem_pkg::*;
();

    localparam string STIM_FILE    = "dv/mem_wb_stim.txt";
    localparam int    RESET_CYCLES = 16;

    // what the DUT should show one cycle after a record was driven
    typedef struct packed {
        logic        full;
        logic        wr_en;
        logic [4:0]  rd;
        logic [31:0] wr_data;
        logic        halt;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        ex_valid;
    ex_mem_t     ex_bundle;
    logic [4:0]  rs_addr;
    wb_id_t      wb_port;
    logic        halt_wb;
    logic [31:0] rs_data;

    expect_t     pending[$];
    logic [31:0] fld [15];
    int          fd;
    int          cur_grp;
    int          grp_checks [8];
    int          grp_errs [8];
    int          bad_records;
    int          wd_limit;

    mem_wb_top #(.WIDTH(32), .BANK_DEPTH(1024)) mem_wb_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_bundle (ex_bundle),
        .rs_addr   (rs_addr),
        .wb_port   (wb_port),
        .halt_wb   (halt_wb),
        .rs_data   (rs_data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        grp_checks[cur_grp]++;
        if (act_val !== exp_val) begin
            grp_errs[cur_grp]++;
            $display("** Error at time %0t: %s expected %h, actual %h",
                     $time, name, exp_val, act_val);
        end
    endtask

    task automatic report_group(input int g);
        $display("test group %0d finished: %0d checks, %0d mismatches",
                 g, grp_checks[g], grp_errs[g]);
    endtask

    // skips comment lines, kind 0 means end of file
    task automatic read_record(output logic [7:0] kind);
        int               n;
        logic [8*256-1:0] rest;
        kind = "#";
        while (kind == "#") begin
            if ($fscanf(fd, " %c", kind) != 1) begin
                kind = 8'd0;
            end else if (kind == "#") begin
                n = $fgets(rest, fd);
            end
        end
        case (kind)
            "I":     n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                                 fld[7], fld[8], fld[9], fld[10], fld[11], fld[12],
                                 fld[13], fld[14]) - 15;
            "N":     n = $fscanf(fd, "%h", fld[0]) - 1;
            "R":     n = $fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]) - 3;
            8'd0:    n = 0;
            default: n = -1;
        endcase
        if (n != 0) begin
            $display("stimulus record of kind '%c' is malformed, reading stopped", kind);
            bad_records++;
            kind = 8'd0;
        end
    endtask

    // idle and register-read records drop ex_valid and hold the last bundle
    task automatic drive_record(input logic [7:0] kind);
        expect_t e;
        e        = '0;
        ex_valid = 1'b0;
        if (kind == "I") begin
            ex_valid             = 1'b1;
            ex_bundle.alu_out    = fld[1];
            ex_bundle.pc_4       = fld[2];
            ex_bundle.store_data = fld[3];
            ex_bundle.funct3     = fld[4][2:0];
            ex_bundle.rd         = fld[5][4:0];
            // a store goes in with reg_wr_en high so mem_wr alone must block the write
            ex_bundle.reg_wr_en  = fld[6][0] | fld[9][0];
            ex_bundle.wb_src     = wb_src_t'(fld[7][1:0]);
            ex_bundle.mem_rd     = fld[8][0];
            ex_bundle.mem_wr     = fld[9][0];
            ex_bundle.halt       = fld[10][0];
            e.full               = 1'b1;
            e.wr_en              = fld[11][0];
            e.rd                 = fld[12][4:0];
            e.wr_data            = fld[13];
            e.halt               = fld[14][0];
        end else if (kind == "R") begin
            rs_addr = fld[1][4:0];
        end
        pending.push_back(e);
    endtask

    task automatic check_result();
        expect_t e;
        if (pending.size() != 0) begin
            e = pending.pop_front();
            compare_value("wb_port.wr_en", 32'(e.wr_en), 32'(wb_port.wr_en));
            compare_value("halt_wb", 32'(e.halt), 32'(halt_wb));
            if (e.full && e.wr_en) begin
                compare_value("wb_port.rd", 32'(e.rd), 32'(wb_port.rd));
                compare_value("wb_port.wr_data", e.wr_data, wb_port.wr_data);
            end
        end
    endtask

    initial begin
        logic [7:0]       kind;
        logic [8*256-1:0] rest;
        logic             started;
        int               n_records;
        int               n_checks;
        int               n_fail;

        rst_n     = 1'b0;
        ex_valid  = 1'b0;
        ex_bundle = '0;
        rs_addr   = '0;
        started   = 1'b0;
        n_records = 0;
        n_checks  = 0;
        n_fail    = 0;
        cur_grp   = 6;

        // first pass only counts records for the watchdog
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            bad_records++;
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind != "#") begin
                    n_records++;
                end
                void'($fgets(rest, fd));
            end
            $fclose(fd);
            fd = $fopen(STIM_FILE, "r");
        end
        wd_limit = n_records * 10 + (RESET_CYCLES + 2) * 10 + 100;

        // reset checks count toward the halt group
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        compare_value("wb_port.wr_en", 32'd0, 32'(wb_port.wr_en));
        compare_value("halt_wb", 32'd0, 32'(halt_wb));
        rst_n = 1'b1;
        pending.push_back('0);

        kind = (fd != 0) ? "#" : 8'd0;
        while (kind != 8'd0) begin
            @(negedge clk);
            check_result();
            read_record(kind);
            if (kind != 8'd0) begin
                if (started && int'(fld[0]) != cur_grp) begin
                    report_group(cur_grp);
                end
                started = 1'b1;
                cur_grp = int'(fld[0]);
                drive_record(kind);
                // rs_data is combinational, settle then look
                if (kind == "R") begin
                    #1;
                    compare_value("rs_data", fld[2], rs_data);
                end
            end
        end
        ex_valid = 1'b0;
        if (started) begin
            report_group(cur_grp);
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        foreach (grp_checks[g]) begin
            n_checks += grp_checks[g];
            n_fail   += grp_errs[g];
        end
        $display("checks %0d, passed %0d, failed %0d, malformed records %0d",
                 n_checks, n_checks - n_fail, n_fail, bad_records);
        if (n_fail == 0 && bad_records == 0 && n_checks > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (wd_limit > 0);
        #(wd_limit);
        $display("watchdog expired after %0d time units, the stimulus did not finish",
                 wd_limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- dv/mem_wb_stim.txt
# I grp alu_out pc_4 store_data funct3 rd reg_wr_en wb_src mem_rd mem_wr halt  wr_en rd data halt
# N grp = idle cycle, R grp rs_addr rs_data = register read, all fields in hex
I 1 00000010 00000104 00000000 0 05 1 0 0 0 0  1 05 00000010 0
I 1 deadbeef 00000108 00000000 0 06 1 1 0 0 0  1 06 00000108 0
I 1 12345678 0000010c 00000000 0 07 1 0 0 0 0  1 07 12345678 0
N 1
I 1 ffffffff 00000110 00000000 0 1f 1 1 0 0 0  1 1f 00000110 0
I 1 00000abc 00000114 00000000 0 08 0 0 0 0 0  0 08 00000000 0
I 1 00000123 00000118 00000000 0 09 1 3 0 0 0  1 09 00000000 0
I 2 00000010 00000200 cafef00d 2 00 0 0 0 1 0  0 00 00000000 0
I 2 00003010 00000204 0badc0de 2 00 0 0 0 1 0  0 00 00000000 0
I 2 00000010 00000208 00000000 2 0a 1 2 1 0 0  1 0a cafef00d 0
I 2 00003010 0000020c 00000000 2 0b 1 2 1 0 0  1 0b 0badc0de 0
I 2 00000020 00000210 11223344 2 00 0 0 0 1 0  0 00 00000000 0
I 2 00000020 00000214 00000000 2 0c 1 2 1 0 0  1 0c 11223344 0
I 2 00003020 00000218 55667788 2 00 0 0 0 1 0  0 00 00000000 0
I 2 00000020 0000021c 00000000 2 0d 1 2 1 0 0  1 0d 11223344 0
I 2 00003020 00000220 00000000 2 0e 1 2 1 0 0  1 0e 55667788 0
I 3 00000040 00000300 80706050 2 00 0 0 0 1 0  0 00 00000000 0
I 3 00000041 00000304 123456a5 0 00 0 0 0 1 0  0 00 00000000 0
I 3 00000043 00000308 000000f1 0 00 0 0 0 1 0  0 00 00000000 0
I 3 00000040 0000030c 00000000 2 10 1 2 1 0 0  1 10 f170a550 0
I 3 00000040 00000310 aaaac3d4 1 00 0 0 0 1 0  0 00 00000000 0
I 3 00000042 00000314 00000009 0 00 0 0 0 1 0  0 00 00000000 0
I 3 00000040 00000318 00000000 2 10 1 2 1 0 0  1 10 f109c3d4 0
I 3 00000043 0000031c 00000000 0 10 1 2 1 0 0  1 10 fffffff1 0
I 3 00000043 00000320 00000000 4 10 1 2 1 0 0  1 10 000000f1 0
I 3 00000042 00000324 00000000 0 10 1 2 1 0 0  1 10 00000009 0
I 3 00000041 00000328 00000000 0 10 1 2 1 0 0  1 10 ffffffc3 0
I 3 00000040 0000032c 00000000 4 10 1 2 1 0 0  1 10 000000d4 0
I 3 00000040 00000330 00000000 1 10 1 2 1 0 0  1 10 ffffc3d4 0
I 3 00000040 00000334 00000000 5 10 1 2 1 0 0  1 10 0000c3d4 0
I 3 00000042 00000338 00000000 1 10 1 2 1 0 0  1 10 fffff109 0
I 3 00000042 0000033c 00000000 5 10 1 2 1 0 0  1 10 0000f109 0
I 3 00003040 00000340 00000000 2 00 0 0 0 1 0  0 00 00000000 0
I 3 00003042 00000344 00007abc 1 00 0 0 0 1 0  0 00 00000000 0
I 3 00003040 00000348 000000ee 0 00 0 0 0 1 0  0 00 00000000 0
I 3 00003040 0000034c 00000000 2 10 1 2 1 0 0  1 10 7abc00ee 0
I 3 00003042 00000350 00000000 1 10 1 2 1 0 0  1 10 00007abc 0
I 3 00003040 00000354 00000000 0 10 1 2 1 0 0  1 10 ffffffee 0
I 4 00001040 00000400 deadbeef 2 00 0 0 0 1 0  0 00 00000000 0
I 4 00002040 00000404 01010101 2 00 0 0 0 1 0  0 00 00000000 0
I 4 00000040 00000408 00000000 2 14 1 2 1 0 0  1 14 f109c3d4 0
I 4 00003040 0000040c 00000000 2 15 1 2 1 0 0  1 15 7abc00ee 0
I 4 00001040 00000410 00000000 2 16 1 2 1 0 0  1 16 00000000 0
I 4 00002040 00000414 00000000 2 17 1 2 1 0 0  1 17 00000000 0
I 4 00001043 00000418 00000000 0 18 1 2 1 0 0  1 18 00000000 0
I 5 000a5a5a 00000500 00000000 0 11 1 0 0 0 0  1 11 000a5a5a 0
N 5
R 5 11 000a5a5a
I 5 77777777 00000504 00000000 0 00 1 0 0 0 0  1 00 77777777 0
N 5
R 5 00 00000000
R 5 07 12345678
I 5 00000000 00000508 00000000 0 11 1 1 0 0 0  1 11 00000508 0
R 5 11 000a5a5a
R 5 11 00000508
N 6
I 6 00000000 00000600 00000000 0 00 0 0 0 0 1  0 00 00000000 1
N 6
I 6 00000abc 00000604 00000000 0 13 1 0 0 0 1  1 13 00000abc 1
I 6 00000def 00000608 00000000 0 14 1 0 0 0 0  1 14 00000def 0
N 6

//--- vlog.f
+incdir+include
verilog/rv_mem_pkg.sv
verilog/data_bank.sv
verilog/mem_access.sv
verilog/write_back.sv
verilog/reg_file.sv
verilog/mem_wb_top.sv
dv/mem_wb_tb.sv

//--- Makefile
SIM  := obj_dir/Vmem_wb_tb
SRCS := $(shell grep -v '^+' vlog.f) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): vlog.f $(SRCS)
	verilator --binary --assert --top-module mem_wb_tb -f vlog.f -o Vmem_wb_tb

run: $(SIM) dv/mem_wb_stim.txt
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
